/* logic/rgmii_pkg.sv */
`default_nettype none

package rgmii_pkg;

    // speed field of the in-band status nibble
    typedef enum logic [1:0] {
        SPEED_10   = 2'd0,
        SPEED_100  = 2'd1,
        SPEED_1000 = 2'd2
    } rgmii_speed_e;

    // in-band status nibble, msb first
    typedef struct packed {
        logic         full_duplex;  // bit 3
        rgmii_speed_e speed;        // bits 2:1
        logic         link_up;      // bit 0
    } rgmii_status_t;

    // one received byte, read as data while dv/er is active, as status when idle
    typedef union packed {
        logic [7:0] data;
        struct packed {
            rgmii_status_t hi;
            rgmii_status_t lo;
        } status;
    } rgmii_rx_byte_u;

    // link down, 10M, half duplex
    localparam rgmii_status_t STATUS_RESET = '{full_duplex: 1'b0,
                                               speed:       SPEED_10,
                                               link_up:     1'b0};

    // default length of the idle run before status is accepted
    localparam int STATUS_STABLE_DEFAULT = 4;

endpackage

`default_nettype wire

/* logic/rgmii_tx_ddr.sv */
`timescale 1ns/10ps
`default_nettype none

module rgmii_tx_ddr (
    input  logic       gmii_tx_clk_i,
    input  logic       gmii_tx_clk90_i,
    input  logic       rst_n_i,
    input  logic [7:0] gmii_txd_i,
    input  logic       gmii_tx_en_i,
    input  logic       gmii_tx_er_i,
    output logic [3:0] rgmii_txd_o,
    output logic       rgmii_tx_ctl_o,
    output logic       rgmii_tx_clk_o
);

    logic [7:0] txd_q;
    logic       tx_en_q;
    logic       tx_ctl2_q;      // second ctl half, en ^ er
    logic [3:0] txd_hi_f;       // high nibble held through the low phase
    logic       tx_ctl2_f;
    logic       clk_fwd_en_q;

    // rising edge bank, same-edge style so both halves come from one cycle
    always_ff @(posedge gmii_tx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            txd_q     <= '0;
            tx_en_q   <= 1'b0;
            tx_ctl2_q <= 1'b0;
        end
        else
        begin
            txd_q     <= gmii_txd_i;
            tx_en_q   <= gmii_tx_en_i;
            tx_ctl2_q <= gmii_tx_en_i ^ gmii_tx_er_i;
        end
    end

    // falling edge copy of the second half
    always_ff @(negedge gmii_tx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            txd_hi_f  <= '0;
            tx_ctl2_f <= 1'b0;
        end
        else
        begin
            txd_hi_f  <= txd_q[7:4];
            tx_ctl2_f <= tx_ctl2_q;
        end
    end

    // high phase carries the low nibble and en
    assign rgmii_txd_o    = gmii_tx_clk_i ? txd_q[3:0] : txd_hi_f;
    assign rgmii_tx_ctl_o = gmii_tx_clk_i ? tx_en_q    : tx_ctl2_f;

    // enable changes in the low phase of clk90 only, no runt pulse on release
    always_ff @(negedge gmii_tx_clk90_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            clk_fwd_en_q <= 1'b0;
        else
            clk_fwd_en_q <= 1'b1;
    end

    assign rgmii_tx_clk_o = gmii_tx_clk90_i & clk_fwd_en_q;  // centered on data

endmodule

`default_nettype wire

/* logic/rgmii_rx_ddr.sv */
`timescale 1ns/10ps
`default_nettype none

module rgmii_rx_ddr
    import rgmii_pkg::*;
(
    input  logic           rgmii_rx_clk_i,
    input  logic           rst_n_i,
    input  logic [3:0]     rgmii_rxd_i,
    input  logic           rgmii_rx_ctl_i,
    output rgmii_rx_byte_u rx_byte_o,
    output logic           rx_dv_o,
    output logic           rx_er_o
);

    logic [3:0]     rxd_r;      // rising edge nibble, bits 3:0
    logic           rx_ctl_r;   // dv half
    logic [3:0]     rxd_f;      // falling edge nibble, bits 7:4
    logic           rx_ctl_f;   // dv ^ er half
    rgmii_rx_byte_u rx_byte_q;
    logic           rx_dv_q;
    logic           rx_er_q;

    always_ff @(posedge rgmii_rx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rxd_r    <= '0;
            rx_ctl_r <= 1'b0;
        end
        else
        begin
            rxd_r    <= rgmii_rxd_i;
            rx_ctl_r <= rgmii_rx_ctl_i;
        end
    end

    always_ff @(negedge rgmii_rx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rxd_f    <= '0;
            rx_ctl_f <= 1'b0;
        end
        else
        begin
            rxd_f    <= rgmii_rxd_i;
            rx_ctl_f <= rgmii_rx_ctl_i;
        end
    end

    // realign both halves onto the next rising edge
    always_ff @(posedge rgmii_rx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rx_byte_q <= '0;
            rx_dv_q   <= 1'b0;
            rx_er_q   <= 1'b0;
        end
        else
        begin
            rx_byte_q.data <= {rxd_f, rxd_r};
            rx_dv_q        <= rx_ctl_r;
            rx_er_q        <= rx_ctl_r ^ rx_ctl_f;  // undo the tx side xor
        end
    end

    assign rx_byte_o = rx_byte_q;
    assign rx_dv_o   = rx_dv_q;
    assign rx_er_o   = rx_er_q;

endmodule

`default_nettype wire

/* logic/rgmii_inband_status.sv */
`timescale 1ns/10ps
`default_nettype none

module rgmii_inband_status
    import rgmii_pkg::*;
#(
    parameter int STATUS_STABLE_CYCLES = STATUS_STABLE_DEFAULT
) (
    input  logic           rgmii_rx_clk_i,
    input  logic           rst_n_i,
    input  rgmii_rx_byte_u rx_byte_i,
    input  logic           rx_dv_i,
    input  logic           rx_er_i,
    output logic           link_up_o,
    output rgmii_speed_e   speed_o,
    output logic           full_duplex_o
);

    localparam int CNT_W = $clog2(STATUS_STABLE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(STATUS_STABLE_CYCLES);

    rgmii_status_t  cand;
    logic           cand_ok;
    logic           same_cand;
    rgmii_status_t  cand_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    rgmii_status_t  status_q;

    // idle byte with both copies agreeing
    assign cand      = rx_byte_i.status.lo;
    assign cand_ok   = !rx_dv_i && !rx_er_i &&
                       (rx_byte_i.status.lo == rx_byte_i.status.hi);
    assign same_cand = (cnt_q != '0) && (cand == cand_q);

    always_comb
    begin
        if (!cand_ok)
            cnt_d = '0;         // data, error or torn status byte
        else if (!same_cand)
            cnt_d = CNT_W'(1);  // new candidate, start over
        else if (cnt_q == CNT_MAX)
            cnt_d = cnt_q;      // saturate
        else
            cnt_d = cnt_q + 1'b1;
    end

    always_ff @(posedge rgmii_rx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            cnt_q    <= '0;
            cand_q   <= STATUS_RESET;
            status_q <= STATUS_RESET;
        end
        else
        begin
            cnt_q <= cnt_d;
            if (cand_ok)
                cand_q <= cand;
            // run long enough, take it
            if (cand_ok && cnt_d == CNT_MAX)
                status_q <= cand;
        end
    end

    assign link_up_o     = status_q.link_up;
    assign speed_o       = status_q.speed;
    assign full_duplex_o = status_q.full_duplex;

endmodule

`default_nettype wire

/* logic/gmii_to_rgmii.sv */
`timescale 1ns/10ps
`default_nettype none

module gmii_to_rgmii
    import rgmii_pkg::*;
#(
    parameter int STATUS_STABLE_CYCLES = STATUS_STABLE_DEFAULT
) (
    input  logic         rst_n_i,
    // MAC transmit side
    input  logic         gmii_tx_clk_i,
    input  logic         gmii_tx_clk90_i,
    input  logic [7:0]   gmii_txd_i,
    input  logic         gmii_tx_en_i,
    input  logic         gmii_tx_er_i,
    // to PHY
    output logic [3:0]   rgmii_txd_o,
    output logic         rgmii_tx_ctl_o,
    output logic         rgmii_tx_clk_o,
    // from PHY
    input  logic [3:0]   rgmii_rxd_i,
    input  logic         rgmii_rx_ctl_i,
    input  logic         rgmii_rx_clk_i,
    // MAC receive side
    output logic         gmii_rx_clk_o,
    output logic [7:0]   gmii_rxd_o,
    output logic         gmii_rx_dv_o,
    output logic         gmii_rx_er_o,
    output logic         link_up_o,
    output rgmii_speed_e speed_o,
    output logic         full_duplex_o
);

    rgmii_tx_ddr u_tx (
        .gmii_tx_clk_i   (gmii_tx_clk_i),
        .gmii_tx_clk90_i (gmii_tx_clk90_i),
        .rst_n_i         (rst_n_i),
        .gmii_txd_i      (gmii_txd_i),
        .gmii_tx_en_i    (gmii_tx_en_i),
        .gmii_tx_er_i    (gmii_tx_er_i),
        .rgmii_txd_o     (rgmii_txd_o),
        .rgmii_tx_ctl_o  (rgmii_tx_ctl_o),
        .rgmii_tx_clk_o  (rgmii_tx_clk_o)
    );

    rgmii_rx_ddr u_rx (
        .rgmii_rx_clk_i (rgmii_rx_clk_i),
        .rst_n_i        (rst_n_i),
        .rgmii_rxd_i    (rgmii_rxd_i),
        .rgmii_rx_ctl_i (rgmii_rx_ctl_i),
        .rx_byte_o      (gmii_rxd_o),      // data view goes to the MAC
        .rx_dv_o        (gmii_rx_dv_o),
        .rx_er_o        (gmii_rx_er_o)
    );

    // same byte, read as status when idle
    rgmii_inband_status #(
        .STATUS_STABLE_CYCLES (STATUS_STABLE_CYCLES)
    ) u_status (
        .rgmii_rx_clk_i (rgmii_rx_clk_i),
        .rst_n_i        (rst_n_i),
        .rx_byte_i      (gmii_rxd_o),
        .rx_dv_i        (gmii_rx_dv_o),
        .rx_er_i        (gmii_rx_er_o),
        .link_up_o      (link_up_o),
        .speed_o        (speed_o),
        .full_duplex_o  (full_duplex_o)
    );

    assign gmii_rx_clk_o = rgmii_rx_clk_i;  // no clock buffer here

endmodule

`default_nettype wire

/* sim/gmii_to_rgmii_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module gmii_to_rgmii_chk
    import rgmii_pkg::*;
(
    input logic         rst_n_i,
    input logic         gmii_tx_clk_i,
    input logic         gmii_tx_en_i,
    input logic         gmii_tx_er_i,
    input logic         rgmii_tx_ctl_o,
    input logic         rgmii_tx_clk_o,
    input logic         gmii_rx_clk_o,
    input logic         gmii_rx_dv_o,
    input logic         gmii_rx_er_o,
    input logic         link_up_o,
    input rgmii_speed_e speed_o,
    input logic         full_duplex_o
);

    logic [1:0] tx_flags_q;         // en, er taken on the last rising edge
    logic       quiet_bad  = 1'b0;
    logic       ctl_hi_bad = 1'b0;
    logic       ctl_lo_bad = 1'b0;
    logic       status_bad = 1'b0;
    logic       any_failed;

    always_ff @(posedge gmii_tx_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            tx_flags_q <= 2'b00;
        else
            tx_flags_q <= {gmii_tx_en_i, gmii_tx_er_i};
    end

    rx_quiet_in_reset: assert property (@(posedge gmii_tx_clk_i)
        !rst_n_i |-> !gmii_rx_dv_o && !gmii_rx_er_o)
        else
        begin
            quiet_bad = 1'b1;
            $error("rx dv or er high in reset");
        end

    // forwarded clock edges sit in the middle of each half
    // high phase carries en
    tx_ctl_high_half: assert property (@(posedge rgmii_tx_clk_o) disable iff (!rst_n_i)
        rgmii_tx_ctl_o == tx_flags_q[1])
        else
        begin
            ctl_hi_bad = 1'b1;
            $error("tx_ctl high half is not en");
        end

    tx_ctl_low_half: assert property (@(negedge rgmii_tx_clk_o) disable iff (!rst_n_i)
        rgmii_tx_ctl_o == ^tx_flags_q)   // en xor er
        else
        begin
            ctl_lo_bad = 1'b1;
            $error("tx_ctl low half is not en xor er");
        end

    status_only_when_idle: assert property (@(negedge gmii_rx_clk_o) disable iff (!rst_n_i)
        !$stable({link_up_o, speed_o, full_duplex_o}) |-> $past(!gmii_rx_dv_o && !gmii_rx_er_o))
        else
        begin
            status_bad = 1'b1;
            $error("status changed after a data byte");
        end

    assign any_failed = quiet_bad | ctl_hi_bad | ctl_lo_bad | status_bad;

endmodule

`default_nettype wire

/* sim/tb_gmii_to_rgmii.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_gmii_to_rgmii
    import rgmii_pkg::*;
();

    localparam int STABLE_RUN    = 4;
    localparam int N_FRAMES      = 60;
    localparam int DRAIN_TIMEOUT = 200;   // tx clock cycles
    localparam rgmii_status_t LINK_DOWN = '{full_duplex: 1'b0, speed: SPEED_10, link_up: 1'b0};

    logic          gmii_tx_clk = 1'b0;
    logic          gmii_tx_clk90 = 1'b0;
    logic          rst_n;
    logic [7:0]    gmii_txd;
    logic          gmii_tx_en;
    logic          gmii_tx_er;
    logic [3:0]    rgmii_txd;           // looped back to the rx pins
    logic          rgmii_tx_ctl;
    logic          rgmii_tx_clk;
    logic          gmii_rx_clk;
    logic [7:0]    gmii_rxd;
    logic          gmii_rx_dv;
    logic          gmii_rx_er;
    logic          link_up;
    rgmii_speed_e  speed;
    logic          full_duplex;

    logic [9:0]    frame_q[$];          // en, er, byte in send order
    rgmii_status_t status_q[$];         // expected status changes in order
    rgmii_status_t model_status;
    logic [3:0]    run_nib;
    int            run_len;
    rgmii_status_t seen_status;
    rgmii_status_t cur_status;
    logic [9:0]    exp_beat;

    always #10 gmii_tx_clk = ~gmii_tx_clk;

    always @(gmii_tx_clk)
    begin
        #5 gmii_tx_clk90 = gmii_tx_clk;   // quarter period late
    end

    gmii_to_rgmii #(
        .STATUS_STABLE_CYCLES (STABLE_RUN)
    ) i_dut (
        .rst_n_i         (rst_n),
        .gmii_tx_clk_i   (gmii_tx_clk),
        .gmii_tx_clk90_i (gmii_tx_clk90),
        .gmii_txd_i      (gmii_txd),
        .gmii_tx_en_i    (gmii_tx_en),
        .gmii_tx_er_i    (gmii_tx_er),
        .rgmii_txd_o     (rgmii_txd),
        .rgmii_tx_ctl_o  (rgmii_tx_ctl),
        .rgmii_tx_clk_o  (rgmii_tx_clk),
        .rgmii_rxd_i     (rgmii_txd),
        .rgmii_rx_ctl_i  (rgmii_tx_ctl),
        .rgmii_rx_clk_i  (rgmii_tx_clk),
        .gmii_rx_clk_o   (gmii_rx_clk),
        .gmii_rxd_o      (gmii_rxd),
        .gmii_rx_dv_o    (gmii_rx_dv),
        .gmii_rx_er_o    (gmii_rx_er),
        .link_up_o       (link_up),
        .speed_o         (speed),
        .full_duplex_o   (full_duplex)
    );

    bind gmii_to_rgmii gmii_to_rgmii_chk i_chk (
        .rst_n_i        (rst_n_i),
        .gmii_tx_clk_i  (gmii_tx_clk_i),
        .gmii_tx_en_i   (gmii_tx_en_i),
        .gmii_tx_er_i   (gmii_tx_er_i),
        .rgmii_tx_ctl_o (rgmii_tx_ctl_o),
        .rgmii_tx_clk_o (rgmii_tx_clk_o),
        .gmii_rx_clk_o  (gmii_rx_clk_o),
        .gmii_rx_dv_o   (gmii_rx_dv_o),
        .gmii_rx_er_o   (gmii_rx_er_o),
        .link_up_o      (link_up_o),
        .speed_o        (speed_o),
        .full_duplex_o  (full_duplex_o)
    );

    task automatic end_with_failure();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_byte(input rgmii_rx_byte_u exp, input rgmii_rx_byte_u act);
        if (act.data !== exp.data)
        begin
            $display("FAILED t=%0t gmii_rxd_o expected %h got %h", $time, exp.data, act.data);
            end_with_failure();
        end
    endtask

    task automatic check_flags(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_status(input rgmii_status_t exp, input rgmii_status_t act);
        if (act !== exp)
        begin
            $display("FAILED t=%0t {full_duplex_o,speed_o,link_up_o} expected %b got %b",
                     $time, exp, act);
            end_with_failure();
        end
    endtask

    function automatic rgmii_status_t dut_status();
        return {full_duplex, speed, link_up};
    endfunction

    // idle run filter fed with every byte as it is sent
    function automatic void track_status(input logic en, input logic er, input logic [7:0] b);
        if (en || er || b[3:0] != b[7:4])
            run_len = 0;
        else if (run_len > 0 && b[3:0] == run_nib)
            run_len++;
        else
        begin
            run_len = 1;
            run_nib = b[3:0];
        end
        if (run_len >= STABLE_RUN && run_nib != model_status)
        begin
            model_status = run_nib;
            status_q.push_back(model_status);
        end
    endfunction

    // one in four idle bytes has a torn copy
    function automatic logic [7:0] pick_idle_byte();
        rgmii_status_t s;
        logic [3:0]    torn;
        s.link_up     = 1'($urandom_range(0, 1));
        s.speed       = rgmii_speed_e'(2'($urandom_range(0, 2)));
        s.full_duplex = 1'($urandom_range(0, 1));
        torn          = s ^ 4'(1 << $urandom_range(0, 3));
        if ($urandom_range(0, 3) == 0)
            return {torn, 4'(s)};
        return {s, s};
    endfunction

    task automatic send_beat(input logic en, input logic er, input logic [7:0] b);
        @(posedge gmii_tx_clk);
        gmii_tx_en <= en;
        gmii_tx_er <= er;
        gmii_txd   <= b;
        if (en)
            frame_q.push_back({en, er, b});
        track_status(en, er, b);
    endtask

    // rx outputs move on the rising edge so look at them half a cycle later
    always @(negedge gmii_rx_clk)
    begin
        if (gmii_rx_dv || gmii_rx_er)
        begin
            if (frame_q.size() == 0)
            begin
                $display("a byte arrived with dv or er high but no byte was sent");
                end_with_failure();
            end
            else
            begin
                exp_beat = frame_q.pop_front();
                check_flags("gmii_rx_dv_o", exp_beat[9], gmii_rx_dv);
                check_flags("gmii_rx_er_o", exp_beat[8], gmii_rx_er);
                check_byte(exp_beat[7:0], gmii_rxd);
            end
        end
        cur_status = dut_status();
        if (cur_status != seen_status)
        begin
            if (status_q.size() == 0)
            begin
                $display("status outputs changed without a stable idle run");
                end_with_failure();
            end
            else
                check_status(status_q.pop_front(), cur_status);
            seen_status = cur_status;
        end
    end

    always @(negedge gmii_tx_clk)
    begin
        if (i_dut.i_chk.any_failed)
        begin
            $display("an assertion in the bound checker failed");
            end_with_failure();
        end
    end

    initial
    begin
        int gap;
        int len;
        logic [7:0] idle_byte;
        void'($urandom(32'hbe60));
        rst_n        = 1'b0;
        gmii_txd     = '0;
        gmii_tx_en   = 1'b0;
        gmii_tx_er   = 1'b0;
        run_len      = 0;
        run_nib      = '0;
        model_status = LINK_DOWN;
        seen_status  = LINK_DOWN;
        repeat (16) @(posedge gmii_tx_clk);
        rst_n <= 1'b1;
        check_status(LINK_DOWN, dut_status());

        for (int f = 0; f < N_FRAMES; f++)
        begin
            gap       = $urandom_range(1, 8);     // some runs too short on purpose
            idle_byte = pick_idle_byte();
            repeat (gap) send_beat(1'b0, 1'b0, idle_byte);
            len = $urandom_range(1, 12);
            for (int i = 0; i < len; i++)
                send_beat(1'b1, ($urandom_range(0, 15) == 0), 8'($urandom));
        end
        repeat (20) send_beat(1'b0, 1'b0, 8'h0f);  // torn idle is never a candidate

        for (int t = 0; t < DRAIN_TIMEOUT && (frame_q.size() != 0 || status_q.size() != 0);
             t++)
            @(posedge gmii_tx_clk);
        if (frame_q.size() != 0)
        begin
            $display("%0d sent bytes never came back on the receive side", frame_q.size());
            end_with_failure();
        end
        else if (status_q.size() != 0)
        begin
            $display("an expected status change never reached the status outputs");
            end_with_failure();
        end
        else
        begin
            check_status(model_status, dut_status());
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
logic/rgmii_pkg.sv
logic/rgmii_tx_ddr.sv
logic/rgmii_rx_ddr.sv
logic/rgmii_inband_status.sv
logic/gmii_to_rgmii.sv
sim/gmii_to_rgmii_chk.sv
sim/tb_gmii_to_rgmii.sv

/* Makefile */
# Verilator simulation of the GMII to RGMII adapter

VERILATOR ?= verilator
TOP       ?= tb_gmii_to_rgmii
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
